// ==== source/elevator_cfg.svh ====
/*
 * Build-time sizes of the elevator floor request logic.
 * Included by the package and by any module that sizes loops or checks on them.
 */

`ifndef ELEVATOR_CFG_SVH
`define ELEVATOR_CFG_SVH

////////////////////
// Building size

// Floors served by the car, floor 0 is the lowest
`define FLOOR_COUNT 11

// Bits needed to hold a floor index
`define FLOOR_WIDTH 4

`endif

// ==== source/elevator_pkg.sv ====
/*
 * Shared types of the elevator floor request logic.
 * Modules name these types in their ports with elevator_pkg:: and import
 * the package in their bodies.
 */

`include "elevator_cfg.svh"

package elevator_pkg;

    // Floor index, 0 is the lowest floor
    typedef logic [`FLOOR_WIDTH-1:0] floor_t;

    // One bit per floor, bit 0 is the lowest floor
    typedef logic [`FLOOR_COUNT-1:0] floor_mask_t;

    ////////////////////
    // Car travel direction

    typedef enum logic {
        DIR_DOWN = 1'b0,
        DIR_UP   = 1'b1
    } direction_e;

    ////////////////////
    // Status reported by the car

    typedef struct packed {
        floor_t     current_floor;
        logic       moving;
        direction_e direction;
        logic       power_on;
        logic       emergency;
    } car_status_t;

    // Lamp pair of one floor
    typedef struct packed {
        logic hall_call;
        logic cab_request;
    } floor_request_t;

    // Door buttons as passed on to the door drive
    typedef struct packed {
        logic open_allowed;
        logic close_allowed;
    } door_command_t;

endpackage

// ==== source/car_service_gate.sv ====
/*
 * Decodes the car status into per-floor latch and clear enables, and gates
 * the door buttons. Purely combinational, one instance at the top level.
 */

module car_service_gate (
    input  elevator_pkg::car_status_t   car_status,
    input  logic                        door_open_button,
    input  logic                        door_close_button,
    output elevator_pkg::floor_mask_t   accept_mask,
    output elevator_pkg::floor_mask_t   clear_mask,
    output elevator_pkg::door_command_t door_command
);
    import elevator_pkg::*;

    floor_mask_t floor_onehot;
    logic        accepting;
    logic        stopped_powered;

    ////////////////////
    // Car condition

    // New requests only while powered and not in emergency
    assign accepting = car_status.power_on && !car_status.emergency;

    // Car standing at a floor with power, doors may work and lamps clear
    assign stopped_powered = car_status.power_on && !car_status.moving;

    // Bit of the floor the car is at
    assign floor_onehot = floor_mask_t'(1) << car_status.current_floor;

    ////////////////////
    // Floor enables

    // A press at the current floor is not taken
    assign accept_mask = accepting ? ~floor_onehot : '0;

    assign clear_mask = stopped_powered ? floor_onehot : '0;

    ////////////////////
    // Door buttons

    assign door_command.open_allowed  = stopped_powered && door_open_button;
    assign door_command.close_allowed = stopped_powered && door_close_button;

    // A floor being cleared must never latch a fresh press in the same cycle
    always_comb begin
        assert #0 ((accept_mask & clear_mask) == '0)
            else $error("accept and clear enables overlap on floor %0d",
                        car_status.current_floor);
    end

endmodule

// ==== source/floor_request_cell.sv ====
/*
 * Hall call and cab request lamps of one floor.
 * The top level builds one cell per floor in a generate loop.
 */

module floor_request_cell (
    input  logic                         clock,
    input  logic                         reset_n,
    input  logic                         hall_button,
    input  logic                         cab_button,
    input  logic                         accept,
    input  logic                         clear,
    output elevator_pkg::floor_request_t request
);
    import elevator_pkg::*;

    floor_request_t next_request;

    ////////////////////
    // Lamp update

    always_comb begin
        next_request = request;
        if (clear) begin
            // Car serves this floor, both lamps go out
            next_request = '0;
        end else if (accept) begin
            if (hall_button) begin
                next_request.hall_call = 1'b1;
            end
            if (cab_button) begin
                next_request.cab_request = 1'b1;
            end
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            request <= '0;
        end else begin
            request <= next_request;
        end
    end

    // After a clear edge the floor must show dark lamps
    assert property (@(posedge clock) disable iff (!reset_n)
        clear |=> (!request.hall_call && !request.cab_request))
        else $error("lamp lit right after floor clear");

endmodule

// ==== source/target_floor_selector.sv ====
/*
 * Picks the next target floor from the pending lamps and registers it.
 * Requests in the present travel direction win, the nearest floor first.
 * Drives travel direction and the activate command from the held target.
 */

`include "elevator_cfg.svh"

module target_floor_selector (
    input  logic                      clock,
    input  logic                      reset_n,
    input  elevator_pkg::floor_mask_t pending_mask,
    input  elevator_pkg::car_status_t car_status,
    output elevator_pkg::floor_t      target_floor,
    output elevator_pkg::direction_e  travel_direction,
    output logic                      activate_elevator
);
    import elevator_pkg::*;

    floor_t above_floor;
    floor_t below_floor;
    floor_t next_target;
    logic   above_found;
    logic   below_found;
    logic   next_valid;
    logic   target_valid;
    logic   reload;

    ////////////////////
    // Nearest pending floors

    // Walk downwards so the lowest floor above the car is kept last
    always_comb begin
        above_floor = '0;
        above_found = 1'b0;
        for (int i = `FLOOR_COUNT - 1; i >= 0; i--) begin
            if (pending_mask[i] && (floor_t'(i) > car_status.current_floor)) begin
                above_floor = floor_t'(i);
                above_found = 1'b1;
            end
        end
    end

    // Walk upwards so the highest floor below the car is kept last
    always_comb begin
        below_floor = '0;
        below_found = 1'b0;
        for (int i = 0; i < `FLOOR_COUNT; i++) begin
            if (pending_mask[i] && (floor_t'(i) < car_status.current_floor)) begin
                below_floor = floor_t'(i);
                below_found = 1'b1;
            end
        end
    end

    ////////////////////
    // Direction priority

    always_comb begin
        next_valid = above_found || below_found;
        if (car_status.direction == DIR_UP) begin
            next_target = above_found ? above_floor : below_floor;
        end else begin
            next_target = below_found ? below_floor : above_floor;
        end
    end

    // New target only once the car rests with nothing left to reach
    assign reload = !car_status.moving &&
                    (!target_valid || (target_floor == car_status.current_floor));

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            target_floor <= '0;
            target_valid <= 1'b0;
        end else if (reload) begin
            target_valid <= next_valid;
            if (next_valid) begin
                target_floor <= next_target;
            end
        end
    end

    ////////////////////
    // Car command

    assign activate_elevator = target_valid &&
                               car_status.power_on &&
                               !car_status.emergency &&
                               !car_status.moving &&
                               (target_floor != car_status.current_floor);

    // Up unless a valid target lies below, so an idle car reports up
    assign travel_direction = (target_valid && (target_floor < car_status.current_floor)) ?
                              DIR_DOWN : DIR_UP;

    assert property (@(posedge clock) disable iff (!reset_n)
        activate_elevator |-> (target_floor != car_status.current_floor))
        else $error("car activated toward the floor it stands at");

    assert property (@(posedge clock) disable iff (!reset_n)
        target_floor < `FLOOR_COUNT)
        else $error("target floor %0d out of range", target_floor);

endmodule

// ==== source/elevator_floor_logic.sv ====
/*
 * Floor request logic of the elevator controller.
 * The status gate enables the per-floor lamp cells, and the selector turns
 * the lit lamps into a target floor and a move command for the car.
 */

`include "elevator_cfg.svh"

module elevator_floor_logic (
    input  logic                        clock,
    input  logic                        reset_n,
    input  elevator_pkg::floor_mask_t   floor_call_buttons,
    input  elevator_pkg::floor_mask_t   panel_buttons,
    input  logic                        door_open_button,
    input  logic                        door_close_button,
    input  elevator_pkg::car_status_t   car_status,
    output elevator_pkg::floor_mask_t   call_button_lights,
    output elevator_pkg::floor_mask_t   panel_button_lights,
    output elevator_pkg::floor_t        target_floor,
    output elevator_pkg::direction_e    travel_direction,
    output logic                        activate_elevator,
    output elevator_pkg::door_command_t door_command
);
    import elevator_pkg::*;

    floor_mask_t    accept_mask;
    floor_mask_t    clear_mask;
    floor_mask_t    pending_mask;
    floor_request_t cell_request [`FLOOR_COUNT];

    ////////////////////
    // Status gate

    car_service_gate u_gate (
        .car_status        (car_status),
        .door_open_button  (door_open_button),
        .door_close_button (door_close_button),
        .accept_mask       (accept_mask),
        .clear_mask        (clear_mask),
        .door_command      (door_command)
    );

    ////////////////////
    // Floor lamps

    for (genvar f = 0; f < `FLOOR_COUNT; f++) begin : g_floor
        floor_request_cell u_cell (
            .clock       (clock),
            .reset_n     (reset_n),
            .hall_button (floor_call_buttons[f]),
            .cab_button  (panel_buttons[f]),
            .accept      (accept_mask[f]),
            .clear       (clear_mask[f]),
            .request     (cell_request[f])
        );

        assign call_button_lights[f]  = cell_request[f].hall_call;
        assign panel_button_lights[f] = cell_request[f].cab_request;
    end

    // Either lamp of a floor makes it a candidate
    assign pending_mask = call_button_lights | panel_button_lights;

    ////////////////////
    // Target selection

    target_floor_selector u_selector (
        .clock             (clock),
        .reset_n           (reset_n),
        .pending_mask      (pending_mask),
        .car_status        (car_status),
        .target_floor      (target_floor),
        .travel_direction  (travel_direction),
        .activate_elevator (activate_elevator)
    );

endmodule

// ==== tests/elevator_tb_checks.svh ====
/*
 * Testbench helpers for the elevator floor request logic.
 * Holds the reference target search, the pseudo-random generator and the
 * typed compare tasks. Included inside the testbench module after the import.
 */

`ifndef ELEVATOR_TB_CHECKS_SVH
`define ELEVATOR_TB_CHECKS_SVH

////////////////////
// Reference model

// Nearest pending floor on the travel side first, then on the other side
function automatic logic ref_select(
    input  floor_mask_t pending,
    input  floor_t      current,
    input  direction_e  direction,
    output floor_t      target
);
    int step;
    int floor_index;
    target = '0;
    step = (direction == DIR_UP) ? 1 : -1;
    for (int side = 0; side < 2; side++) begin
        for (int distance = 1; distance < `FLOOR_COUNT; distance++) begin
            floor_index = int'(current) + distance * step;
            if (floor_index >= 0 && floor_index < `FLOOR_COUNT && pending[floor_index]) begin
                target = floor_t'(floor_index);
                return 1'b1;
            end
        end
        step = -step;
    end
    return 1'b0;
endfunction

// 32-bit xorshift step
function automatic logic [31:0] xorshift(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

////////////////////
// Compare tasks

task automatic stop_on_failure();
    $display("Simulation failed");
    $fatal(1, "run stopped at the first failure");
endtask

task automatic check_mask(input string name, input floor_mask_t actual,
                          input floor_mask_t expected);
    if (actual !== expected) begin
        $display("ERROR at %0t: %s expected %h, got %h", $time, name, expected, actual);
        stop_on_failure();
    end
endtask

task automatic check_floor(input string name, input floor_t actual, input floor_t expected);
    if (actual !== expected) begin
        $display("ERROR at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
        stop_on_failure();
    end
endtask

task automatic check_direction(input string name, input direction_e actual,
                               input direction_e expected);
    if (actual !== expected) begin
        $display("ERROR at %0t: %s expected %0b, got %0b", $time, name, expected, actual);
        stop_on_failure();
    end
endtask

task automatic check_bit(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
        $display("ERROR at %0t: %s expected %b, got %b", $time, name, expected, actual);
        stop_on_failure();
    end
endtask

task automatic check_door(input string name, input door_command_t actual,
                          input door_command_t expected);
    if (actual !== expected) begin
        $display("ERROR at %0t: %s expected %b, got %b", $time, name, expected, actual);
        stop_on_failure();
    end
endtask

`endif

// ==== tests/elevator_floor_logic_tb.sv ====
/*
 * Testbench of the elevator floor request logic.
 * A lamp and target model runs beside the DUT and is compared after every
 * rising clock edge. Directed and random stimulus changes on the falling edge.
 */

`include "elevator_cfg.svh"

module elevator_floor_logic_tb;
    import elevator_pkg::*;

    localparam int CLOCK_PERIOD  = 40;
    localparam int RESET_CYCLES  = 10;
    localparam int WAIT_LIMIT    = 20;
    localparam int RANDOM_ROUNDS = 400;

    logic          clock;
    logic          reset_n;
    floor_mask_t   floor_call_buttons;
    floor_mask_t   panel_buttons;
    logic          door_open_button;
    logic          door_close_button;
    car_status_t   car_status;
    floor_mask_t   call_button_lights;
    floor_mask_t   panel_button_lights;
    floor_t        target_floor;
    direction_e    travel_direction;
    logic          activate_elevator;
    door_command_t door_command;

    // Model state owned by the compare process
    floor_mask_t model_hall;
    floor_mask_t model_cab;
    floor_t      model_target;
    logic        model_valid;
    logic [31:0] rng_state;

    `include "elevator_tb_checks.svh"

    elevator_floor_logic elevator_floor_logic_inst (
        .clock               (clock),
        .reset_n             (reset_n),
        .floor_call_buttons  (floor_call_buttons),
        .panel_buttons       (panel_buttons),
        .door_open_button    (door_open_button),
        .door_close_button   (door_close_button),
        .car_status          (car_status),
        .call_button_lights  (call_button_lights),
        .panel_button_lights (panel_button_lights),
        .target_floor        (target_floor),
        .travel_direction    (travel_direction),
        .activate_elevator   (activate_elevator),
        .door_command        (door_command)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    ////////////////////
    // Model and compare

    always begin : compare_process
        floor_mask_t   floor_bit;
        floor_mask_t   accept;
        floor_mask_t   clear;
        floor_t        next_target;
        logic          next_valid;
        logic          stopped_powered;
        logic          expect_activate;
        direction_e    expect_direction;
        door_command_t expect_door;
        @(posedge clock);
        stopped_powered = car_status.power_on && !car_status.moving;
        floor_bit = '0;
        floor_bit[car_status.current_floor] = 1'b1;
        accept = (car_status.power_on && !car_status.emergency) ? ~floor_bit : '0;
        clear = stopped_powered ? floor_bit : '0;
        if (!reset_n) begin
            model_hall = '0;
            model_cab = '0;
            model_target = '0;
            model_valid = 1'b0;
        end else begin
            // Target search sees the lamps as they were before this edge
            next_valid = ref_select(model_hall | model_cab, car_status.current_floor,
                                    car_status.direction, next_target);
            if (!car_status.moving &&
                (!model_valid || model_target == car_status.current_floor)) begin
                model_valid = next_valid;
                if (next_valid) begin
                    model_target = next_target;
                end
            end
            model_hall = (model_hall | (floor_call_buttons & accept)) & ~clear;
            model_cab = (model_cab | (panel_buttons & accept)) & ~clear;
        end
        #1;
        expect_activate = model_valid && car_status.power_on && !car_status.emergency &&
                          !car_status.moving && (model_target != car_status.current_floor);
        expect_direction = (model_valid && model_target < car_status.current_floor) ?
                           DIR_DOWN : DIR_UP;
        expect_door.open_allowed = stopped_powered && door_open_button;
        expect_door.close_allowed = stopped_powered && door_close_button;
        check_mask("call_button_lights", call_button_lights, model_hall);
        check_mask("panel_button_lights", panel_button_lights, model_cab);
        check_floor("target_floor", target_floor, model_target);
        check_bit("activate_elevator", activate_elevator, expect_activate);
        check_direction("travel_direction", travel_direction, expect_direction);
        check_door("door_command", door_command, expect_door);
    end

    ////////////////////
    // Stimulus helpers

    task automatic set_car(input floor_t floor_now, input logic moving,
                           input direction_e direction, input logic power_on,
                           input logic emergency);
        car_status.current_floor = floor_now;
        car_status.moving = moving;
        car_status.direction = direction;
        car_status.power_on = power_on;
        car_status.emergency = emergency;
    endtask

    // Buttons held for one clock and then released
    task automatic press_buttons(input floor_mask_t hall, input floor_mask_t cab);
        floor_call_buttons = hall;
        panel_buttons = cab;
        @(negedge clock);
        floor_call_buttons = '0;
        panel_buttons = '0;
    endtask

    task automatic wait_for_target(input floor_t floor_expected);
        int cycles;
        cycles = 0;
        while (!(activate_elevator && target_floor == floor_expected) &&
               cycles < WAIT_LIMIT) begin
            @(negedge clock);
            cycles++;
        end
        if (!(activate_elevator && target_floor === floor_expected)) begin
            $display("Timeout: car not sent to floor %0d within %0d cycles",
                     floor_expected, WAIT_LIMIT);
            stop_on_failure();
        end
    endtask

    task automatic wait_for_lamps_clear(input floor_t floor_index);
        int cycles;
        cycles = 0;
        while ((call_button_lights[floor_index] || panel_button_lights[floor_index]) &&
               cycles < WAIT_LIMIT) begin
            @(negedge clock);
            cycles++;
        end
        if (call_button_lights[floor_index] !== 1'b0 ||
            panel_button_lights[floor_index] !== 1'b0) begin
            $display("Timeout: lamps of floor %0d still lit after %0d cycles",
                     floor_index, WAIT_LIMIT);
            stop_on_failure();
        end
    endtask

    ////////////////////
    // Test sequence

    initial begin
        int hold;
        rng_state = 32'd8;
        reset_n = 1'b0;
        floor_call_buttons = '0;
        panel_buttons = '0;
        door_open_button = 1'b0;
        door_close_button = 1'b0;
        set_car(4'd0, 1'b0, DIR_UP, 1'b0, 1'b0);
        repeat (RESET_CYCLES) @(negedge clock);
        reset_n = 1'b1;
        @(negedge clock);
        check_mask("call_button_lights", call_button_lights, '0);
        check_bit("activate_elevator", activate_elevator, 1'b0);

        // Resting at floor 3 heading up with calls above and below
        set_car(4'd3, 1'b0, DIR_UP, 1'b1, 1'b0);
        press_buttons(11'b000_1000_0000, 11'b000_0000_0010);
        wait_for_target(4'd7);

        // Power off and then emergency with presses that must stay dark
        set_car(4'd3, 1'b0, DIR_UP, 1'b0, 1'b0);
        door_open_button = 1'b1;
        press_buttons(11'b010_0000_0000, '0);
        door_open_button = 1'b0;
        set_car(4'd3, 1'b1, DIR_UP, 1'b1, 1'b1);
        set_car(4'd3, 1'b0, DIR_UP, 1'b1, 1'b1);
        press_buttons('0, 11'b100_0000_0000);
        @(negedge clock);
        check_mask("call_button_lights", call_button_lights, 11'b000_1000_0000);
        check_mask("panel_button_lights", panel_button_lights, 11'b000_0000_0010);

        // A moving car takes presses except at the floor it is passing
        set_car(4'd3, 1'b1, DIR_UP, 1'b1, 1'b0);
        press_buttons(11'b000_0000_1000, 11'b000_0010_0000);
        @(negedge clock);
        check_mask("call_button_lights", call_button_lights, 11'b000_1000_0000);
        check_mask("panel_button_lights", panel_button_lights, 11'b000_0010_0010);

        // Arrival at floor 7 clears its lamps and turns the car down to 5
        set_car(4'd7, 1'b0, DIR_UP, 1'b1, 1'b0);
        wait_for_lamps_clear(4'd7);
        check_mask("call_button_lights", call_button_lights, '0);
        check_mask("panel_button_lights", panel_button_lights, 11'b000_0010_0010);
        wait_for_target(4'd5);
        check_direction("travel_direction", travel_direction, DIR_DOWN);

        // Random floors, directions, motion and sparse presses
        for (int round = 0; round < RANDOM_ROUNDS; round++) begin
            rng_state = xorshift(rng_state);
            car_status.current_floor = floor_t'(rng_state % `FLOOR_COUNT);
            car_status.moving = (rng_state[8:6] == 3'd0);
            car_status.direction = direction_e'(rng_state[9]);
            car_status.power_on = (rng_state[12:10] != 3'd0);
            car_status.emergency = (rng_state[15:13] == 3'd0);
            door_open_button = rng_state[16];
            door_close_button = rng_state[17];
            rng_state = xorshift(rng_state);
            floor_call_buttons = rng_state[`FLOOR_COUNT-1:0] & rng_state[`FLOOR_COUNT+10:11];
            panel_buttons = rng_state[`FLOOR_COUNT+15:16] & rng_state[`FLOOR_COUNT+4:5];
            hold = 1 + rng_state[31:30];
            repeat (hold) @(negedge clock);
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+source
+incdir+tests
source/elevator_pkg.sv
source/car_service_gate.sv
source/floor_request_cell.sv
source/target_floor_selector.sv
source/elevator_floor_logic.sv
tests/elevator_floor_logic_tb.sv
